// File: include/bp_settings.svh
// predictor sizing; every size is a power of two and BP_GH_LENGTH must equal BP_LOG_PHT_SETS + BP_LOG_FETCH_LANES
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// ----------------------------------------------------------------------
// fetch block geometry
// ----------------------------------------------------------------------

// log2 of the instruction lanes per fetch block
`define BP_LOG_FETCH_LANES 2

// ----------------------------------------------------------------------
// pattern history table
// ----------------------------------------------------------------------

// log2 of the number of counter sets
`define BP_LOG_PHT_SETS 6

// global history bits, upper part hashes the index, lower part the lane
`define BP_GH_LENGTH 8

// ----------------------------------------------------------------------
// architectural widths
// ----------------------------------------------------------------------

// address-space id
`define BP_ASID_WIDTH 4

// byte address of an instruction
`define BP_PC_WIDTH 38

`endif

// File: hw/bp_pkg.sv
// predictor types and pc slicing; pcs are byte addresses of 4-byte instructions
`default_nettype none

`include "bp_settings.svh"

package bp_pkg;

    // ------------------------------------------------------------------
    // field types
    // ------------------------------------------------------------------

    typedef logic [`BP_LOG_PHT_SETS-1:0]    fetch_idx_t;
    typedef logic [`BP_LOG_FETCH_LANES-1:0] fetch_lane_t;

    // newest resolved direction sits in bit 0
    typedef logic [`BP_GH_LENGTH-1:0]       GH_t;
    typedef logic [`BP_ASID_WIDTH-1:0]      ASID_t;
    typedef logic [`BP_PC_WIDTH-1:0]        PC38_t;
    typedef logic [`BP_LOG_PHT_SETS-1:0]    PHT_idx_t;

    // two-bit counter as {taken, strong}
    typedef logic [1:0] tbc_t;

    localparam tbc_t TBC_WN = 2'b00;
    localparam tbc_t TBC_SN = 2'b01;
    localparam tbc_t TBC_WT = 2'b10;
    localparam tbc_t TBC_ST = 2'b11;

    // one counter per lane
    typedef tbc_t [(1 << `BP_LOG_FETCH_LANES)-1:0] PHT_set_t;

    // ------------------------------------------------------------------
    // request and update bundles
    // ------------------------------------------------------------------

    typedef struct packed {
        fetch_idx_t fetch_index;
    } pht_read_req_t;

    typedef struct packed {
        PC38_t  pc38;
        GH_t    gh;
        logic   taken;
    } pht_update_t;

    // ------------------------------------------------------------------
    // pc slicing
    // ------------------------------------------------------------------

    // set index sits just above the lane bits
    function automatic fetch_idx_t fetch_idx_bits(PC38_t pc);
        return pc[2 + `BP_LOG_FETCH_LANES + `BP_LOG_PHT_SETS - 1 : 2 + `BP_LOG_FETCH_LANES];
    endfunction

    // lane bits sit above the 4-byte instruction offset
    function automatic fetch_lane_t fetch_lane_bits(PC38_t pc);
        return pc[2 + `BP_LOG_FETCH_LANES - 1 : 2];
    endfunction

endpackage

`default_nettype wire

// File: hw/bram_2rport_1wport.sv
// flop-based ram with two registered read ports; INNER_WIDTH must be a multiple of 8, reads see pre-write data
`default_nettype none
`timescale 1ns/1ps

module bram_2rport_1wport #(
    parameter int INNER_WIDTH = 8,
    parameter int OUTER_WIDTH = 64
) (
    input  logic                            CLK,
    input  logic                            nRST,

    // read port 0
    input  logic                            port0_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0]  port0_rindex,
    output logic [INNER_WIDTH-1:0]          port0_rdata,

    // read port 1
    input  logic                            port1_ren,
    input  logic [$clog2(OUTER_WIDTH)-1:0]  port1_rindex,
    output logic [INNER_WIDTH-1:0]          port1_rdata,

    // byte-enabled write port
    input  logic [INNER_WIDTH/8-1:0]        wen_byte,
    input  logic [$clog2(OUTER_WIDTH)-1:0]  windex,
    input  logic [INNER_WIDTH-1:0]          wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // ------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < OUTER_WIDTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int b = 0; b < INNER_WIDTH / 8; b++) begin
                if (wen_byte[b]) begin
                    mem[windex][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------------

    // nonblocking reads return the word as it was before this edge's write
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            port0_rdata <= '0;
            port1_rdata <= '0;
        end else begin
            if (port0_ren) begin
                port0_rdata <= mem[port0_rindex];
            end
            if (port1_ren) begin
                port1_rdata <= mem[port1_rindex];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/ghr.sv
// resolved-direction global history; shifts at the edge that accepts an update, no repair on mispredict
`default_nettype none
`timescale 1ns/1ps

module ghr (
    input  logic        CLK,
    input  logic        nRST,

    // resolved branch
    input  logic        update_valid,
    input  logic        update_taken,

    // current history, newest outcome in bit 0
    output bp_pkg::GH_t cur_gh
);

    import bp_pkg::*;

    GH_t next_gh;

    // ------------------------------------------------------------------
    // shift register
    // ------------------------------------------------------------------

    // oldest outcome drops off the top
    always_comb begin
        next_gh = cur_gh;
        if (update_valid) begin
            next_gh = {cur_gh[$bits(GH_t)-2:0], update_taken};
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            cur_gh <= '0;
        end else begin
            cur_gh <= next_gh;
        end
    end

endmodule

`default_nettype wire

// File: hw/pht.sv
// gshare pattern history table; one-cycle read latency, updates write one cycle after acceptance, no back-pressure
`default_nettype none
`timescale 1ns/1ps

`include "bp_settings.svh"

module pht (
    input  logic                    CLK,
    input  logic                    nRST,

    input  bp_pkg::ASID_t           arch_asid,

    // read request stage
    input  logic                    read_req_valid,
    input  bp_pkg::pht_read_req_t   read_req,
    input  bp_pkg::GH_t             read_gh,

    // read response stage
    input  bp_pkg::fetch_lane_t     read_resp_redirect_lane,
    output logic                    read_resp_taken,

    // resolved branch update
    input  logic                    update_valid,
    input  bp_pkg::pht_update_t     update
);

    import bp_pkg::*;

    // asid bits folded into the top of the index
    localparam int ASID_FOLD = (`BP_LOG_PHT_SETS < `BP_ASID_WIDTH) ?
                               `BP_LOG_PHT_SETS : `BP_ASID_WIDTH;

    // ------------------------------------------------------------------
    // hashing and counter step
    // ------------------------------------------------------------------

    // upper history above the lane bits, asid reversed from the msb
    function automatic PHT_idx_t index_hash(fetch_idx_t idx, GH_t gh, ASID_t asid);
        PHT_idx_t h;
        h = idx ^ gh[`BP_GH_LENGTH-1:`BP_LOG_FETCH_LANES];
        for (int i = 0; i < ASID_FOLD; i++) begin
            h[`BP_LOG_PHT_SETS-1-i] ^= asid[i];
        end
        return h;
    endfunction

    function automatic fetch_lane_t lane_hash(fetch_lane_t lane, GH_t gh);
        return lane ^ gh[`BP_LOG_FETCH_LANES-1:0];
    endfunction

    // weak states fall to strong on the first opposite outcome
    function automatic tbc_t tbc_next(tbc_t cur, logic taken);
        tbc_t nxt;
        case (cur)
            TBC_ST:  nxt = taken ? TBC_ST : TBC_WT;
            TBC_SN:  nxt = taken ? TBC_WN : TBC_SN;
            default: nxt = taken ? TBC_ST : TBC_SN;
        endcase
        return nxt;
    endfunction

    // ------------------------------------------------------------------
    // signals
    // ------------------------------------------------------------------

    // read path
    PHT_idx_t       rd_idx;
    PHT_set_t       rd_set;
    GH_t            rd_resp_gh;
    fetch_lane_t    rd_lane;

    // update read stage
    PHT_idx_t       upd_idx;
    PHT_set_t       upd_set;

    // update write stage
    logic                           wr_valid;
    logic                           wr_forward;
    PHT_idx_t                       wr_idx;
    fetch_lane_t                    wr_lane;
    logic                           wr_taken;
    PHT_set_t                       wr_last_set;
    PHT_set_t                       wr_old_set;
    PHT_set_t                       wr_set;
    logic [$bits(PHT_set_t)/8-1:0]  wr_byte_en;

    // ------------------------------------------------------------------
    // read path
    // ------------------------------------------------------------------

    assign rd_idx = index_hash(read_req.fetch_index, read_gh, arch_asid);

    // history travels with the request into the response cycle
    always_ff @(posedge CLK) begin
        rd_resp_gh <= read_gh;
    end

    assign rd_lane         = lane_hash(read_resp_redirect_lane, rd_resp_gh);
    assign read_resp_taken = rd_set[rd_lane][1];

    // ------------------------------------------------------------------
    // update path
    // ------------------------------------------------------------------

    assign upd_idx = index_hash(fetch_idx_bits(update.pc38), update.gh, arch_asid);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wr_valid   <= 1'b0;
            wr_forward <= 1'b0;
        end else begin
            wr_valid   <= update_valid;
            // array still holds the old set, so take the one being written now
            wr_forward <= update_valid & wr_valid & (upd_idx == wr_idx);
        end
    end

    always_ff @(posedge CLK) begin
        wr_idx      <= upd_idx;
        wr_lane     <= lane_hash(fetch_lane_bits(update.pc38), update.gh);
        wr_taken    <= update.taken;
        wr_last_set <= wr_set;
    end

    always_comb begin
        wr_old_set = wr_forward ? wr_last_set : upd_set;
        wr_set     = wr_old_set;
        wr_set[wr_lane] = tbc_next(wr_old_set[wr_lane], wr_taken);
    end

    assign wr_byte_en = {$bits(wr_byte_en){wr_valid}};

    // ------------------------------------------------------------------
    // counter array
    // ------------------------------------------------------------------

    bram_2rport_1wport #(
        .INNER_WIDTH ($bits(PHT_set_t)),
        .OUTER_WIDTH (1 << `BP_LOG_PHT_SETS)
    ) u_pht_array (
        .CLK          (CLK),
        .nRST         (nRST),
        .port0_ren    (read_req_valid),
        .port0_rindex (rd_idx),
        .port0_rdata  (rd_set),
        .port1_ren    (update_valid),
        .port1_rindex (upd_idx),
        .port1_rdata  (upd_set),
        .wen_byte     (wr_byte_en),
        .windex       (wr_idx),
        .wdata        (wr_set)
    );

endmodule

`default_nettype wire

// File: hw/bp_top.sv
// predictor slice top; valid-only handshake, response one cycle after the request, lane presented in that cycle
`default_nettype none
`timescale 1ns/1ps

module bp_top (
    input  logic                    CLK,
    input  logic                    nRST,

    input  bp_pkg::ASID_t           arch_asid,

    // prediction request and response
    input  logic                    read_req_valid,
    input  bp_pkg::pht_read_req_t   read_req,
    input  bp_pkg::fetch_lane_t     read_resp_redirect_lane,
    output logic                    read_resp_taken,

    // resolved branches
    input  logic                    update_valid,
    input  bp_pkg::pht_update_t     update,

    // history for fetch to snapshot
    output bp_pkg::GH_t             cur_gh
);

    // ------------------------------------------------------------------
    // global history
    // ------------------------------------------------------------------

    ghr u_ghr (
        .CLK          (CLK),
        .nRST         (nRST),
        .update_valid (update_valid),
        .update_taken (update.taken),
        .cur_gh       (cur_gh)
    );

    // ------------------------------------------------------------------
    // pattern history table
    // ------------------------------------------------------------------

    pht u_pht (
        .CLK                     (CLK),
        .nRST                    (nRST),
        .arch_asid               (arch_asid),
        .read_req_valid          (read_req_valid),
        .read_req                (read_req),
        .read_gh                 (cur_gh),
        .read_resp_redirect_lane (read_resp_redirect_lane),
        .read_resp_taken         (read_resp_taken),
        .update_valid            (update_valid),
        .update                  (update)
    );

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
// free-running clock from time 0; nRST rises on the falling edge after RESET_CYCLES rising edges
`default_nettype none
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // reset held low across the first RESET_CYCLES rising edges
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_bp_top.sv
// run from the project root; a U line runs under the ASID of the last R line, R and U take one cycle each
`default_nettype none
`timescale 1ns/1ps

module tb_bp_top;

    import bp_pkg::*;

    localparam string STIM_PATH      = "sim/bp_stimulus.txt";
    localparam int    RESET_CYCLES   = 8;
    localparam int    TIMEOUT_MARGIN = 20;

    // one parsed line, argument meaning depends on the op letter
    typedef struct packed {
        logic [7:0]  kind;
        logic [39:0] arg0;
        logic [39:0] arg1;
        logic [39:0] arg2;
        logic [39:0] arg3;
        logic [39:0] arg4;
    } stim_op_t;

    logic           CLK;
    logic           nRST;
    ASID_t          arch_asid;
    logic           read_req_valid;
    pht_read_req_t  read_req;
    fetch_lane_t    read_resp_redirect_lane;
    logic           read_resp_taken;
    logic           update_valid;
    pht_update_t    update;
    GH_t            cur_gh;

    stim_op_t       ops[$];
    int             pass_count;
    int             fail_count;
    int             cycle_count;
    int             cycle_limit;

    clk_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    bp_top u_dut (
        .CLK                     (CLK),
        .nRST                    (nRST),
        .arch_asid               (arch_asid),
        .read_req_valid          (read_req_valid),
        .read_req                (read_req),
        .read_resp_redirect_lane (read_resp_redirect_lane),
        .read_resp_taken         (read_resp_taken),
        .update_valid            (update_valid),
        .update                  (update)
        ,
        .cur_gh                  (cur_gh)
    );

    // ----------------------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------------------

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // stimulus file
    // ----------------------------------------------------------------------

    // fills ops and sums the cycles that the ops take
    task automatic load_stimulus(output bit ok, output int cycles);
        int               fd;
        int               n;
        bit               done;
        logic [7:0]       op_ch;
        logic [8*160-1:0] rest;
        logic [39:0]      a0;
        logic [39:0]      a1;
        logic [39:0]      a2;
        logic [39:0]      a3;
        logic [39:0]      a4;
        stim_op_t         op;
        ok     = 1'b1;
        cycles = 0;
        done   = 1'b0;
        fd     = $fopen(STIM_PATH, "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while (!done) begin
                n = $fscanf(fd, " %c", op_ch);
                a0 = '0;
                a1 = '0;
                a2 = '0;
                a3 = '0;
                a4 = '0;
                if (n != 1) begin
                    done = 1'b1;
                end else if (op_ch == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    case (op_ch)
                        "R": ok = ($fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4) == 5);
                        "U": ok = ($fscanf(fd, "%h %h %h", a0, a1, a2) == 3);
                        "I": ok = ($fscanf(fd, "%h", a0) == 1);
                        default: ok = 1'b0;
                    endcase
                    op = '{kind: op_ch, arg0: a0, arg1: a1, arg2: a2, arg3: a3, arg4: a4};
                    ops.push_back(op);
                    cycles = cycles + ((op_ch == "I") ? int'(a0) : 1);
                    if (!ok) begin
                        done = 1'b1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------

    task automatic check_taken(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            pass_count++;
            $display("[PASS] %s: %0b", name, actual);
        end else begin
            fail_count++;
            $display("[ERROR] %s: expected %0b, actual %0b", name, expected, actual);
        end
    endtask

    task automatic check_gh(input string name, input GH_t expected, input GH_t actual);
        if (actual === expected) begin
            pass_count++;
            $display("[PASS] %s: %02h", name, actual);
        end else begin
            fail_count++;
            $display("[ERROR] %s: expected %02h, actual %02h", name, expected, actual);
        end
    endtask

    // ----------------------------------------------------------------------
    // op drivers, each entered on a falling edge
    // ----------------------------------------------------------------------

    // lane is held through the response cycle, sampled at the next falling edge
    task automatic apply_read(input int idx, input stim_op_t op);
        logic taken_now;
        GH_t  gh_now;
        update_valid             = 1'b0;
        read_req_valid           = 1'b1;
        read_req.fetch_index     = fetch_idx_t'(op.arg0);
        arch_asid                = ASID_t'(op.arg1);
        read_resp_redirect_lane  = fetch_lane_t'(op.arg2);
        @(negedge CLK);
        taken_now      = read_resp_taken;
        gh_now         = cur_gh;
        read_req_valid = 1'b0;
        check_taken($sformatf("op %0d read taken", idx), op.arg3[0], taken_now);
        check_gh($sformatf("op %0d cur_gh", idx), GH_t'(op.arg4), gh_now);
    endtask

    task automatic apply_update(input stim_op_t op);
        read_req_valid = 1'b0;
        update_valid   = 1'b1;
        update.pc38    = PC38_t'(op.arg0);
        update.gh      = GH_t'(op.arg1);
        update.taken   = op.arg2[0];
        @(negedge CLK);
        update_valid = 1'b0;
    endtask

    task automatic apply_idle(input stim_op_t op);
        read_req_valid = 1'b0;
        update_valid   = 1'b0;
        repeat (int'(op.arg0)) @(negedge CLK);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial begin : main
        bit ok;
        int cycles;
        arch_asid               = '0;
        read_req_valid          = 1'b0;
        read_req                = '0;
        read_resp_redirect_lane = '0;
        update_valid            = 1'b0;
        update                  = '0;
        pass_count              = 0;
        fail_count              = 0;
        cycle_count             = 0;
        cycle_limit             = 0;
        load_stimulus(ok, cycles);
        if (!ok) begin
            $display("stimulus file %s is missing or has a malformed line", STIM_PATH);
            $display("TEST FAIL");
            $finish;
        end else begin
            cycle_limit = cycles + RESET_CYCLES + TIMEOUT_MARGIN;
            @(posedge nRST);
            for (int i = 0; i < ops.size(); i++) begin
                case (ops[i].kind)
                    "R":     apply_read(i, ops[i]);
                    "U":     apply_update(ops[i]);
                    default: apply_idle(ops[i]);
                endcase
            end
            $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hw/bp_pkg.sv
hw/bram_2rport_1wport.sv
hw/ghr.sv
hw/pht.sv
hw/bp_top.sv
sim/clk_gen.sv
sim/tb_bp_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, then judge the run from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_bp_top -f src.f > sim.log 2>&1 \
    && ./obj_dir/Vtb_bp_top >> sim.log 2>&1 \
    || echo "build or simulation exited with an error" >> sim.log

if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"

// File: sim/bp_stimulus.txt
# R fetch_index asid lane exp_taken exp_cur_gh | U pc gh taken | I idle_cycles
# every field is hex; a U line runs under the ASID of the previous R line
# reset: all counters weakly not-taken, history clear
R 00 0 0 0 00
R 15 3 2 0 00
R 3f 0 3 0 00
# taken update to set 05 lane 0, read one cycle later still old, then new
U 0000000054 01 1
R 05 0 1 0 01
R 05 0 1 1 01
# two not-taken steps, ST to WT then SN
U 0000000054 01 0
I 1
R 05 0 2 1 02
U 0000000054 01 0
I 1
R 04 0 0 0 04
# lane isolation in set 08 with history 09
U 00000000a8 09 1
I 1
R 0a 0 2 1 09
R 0a 0 0 0 09
R 0a 0 1 0 09
R 0a 0 3 0 09
# back-to-back updates to set 39, lanes 3 and 2
U 0000000300 27 1
U 0000000304 27 1
I 1
R 30 0 0 1 27
R 30 0 1 1 27
R 30 0 2 0 27
R 30 0 3 0 27
# asid 1 moves the index to set 19
R 30 1 0 0 27
U 0000000300 27 0
I 1
# history 4e moves fetch index 30 to set 23, index 2a lands on set 39
R 30 0 0 0 4e
R 2a 0 1 1 4e
R 2a 2 1 0 4e
R 2a 1 1 0 4e
